//--- Makefile
TOOL     := verilator
TOP      := alu_unit_tb
FILELIST := filelist.f
BUILD    := obj_dir
FLAGS    := --binary --timing --assert --timescale 1ns/10ps -j 0

SOURCES  := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# exit status of the simulation binary is the test result
run: compile
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

//--- design/alu_execute.sv
`timescale 1ns/10ps
`default_nettype none

module alu_execute #(
    parameter int NUM_SLOTS = 8
) (
    input  alu_pkg::status_t     [NUM_SLOTS-1:0] slot_status,
    input  alu_pkg::slot_entry_t [NUM_SLOTS-1:0] slot_entry,
    output alu_pkg::reg_addr_t                   rs_addr,
    output alu_pkg::reg_addr_t                   rt_addr,
    input  alu_pkg::word_t                       rs_data,
    input  alu_pkg::word_t                       rt_data,
    input  alu_pkg::tag_t                        alloc_tag,
    output logic                                 res_wr_en,
    output alu_pkg::word_t                       res_data,
    output alu_pkg::pick_t                       exec_pick
);

    logic                 sel_found;
    alu_pkg::slot_idx_t   sel_idx;
    alu_pkg::slot_entry_t sel_entry;
    alu_pkg::word_t       op_a;
    alu_pkg::word_t       op_b;
    logic [4:0]           shamt;
    alu_pkg::word_t       result;

    // oldest first, highest index wins
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (!sel_found && slot_status[i] == alu_pkg::ST_EXEC_READY &&
                alu_pkg::op_supported(slot_entry[i].opcode)) begin
                sel_found = 1'b1;
                sel_idx   = alu_pkg::slot_idx_t'(i);
            end
        end
    end

    assign sel_entry = slot_entry[sel_idx];

    // operand fetch from the register file, same cycle
    assign rs_addr = sel_entry.rs;
    assign rt_addr = sel_entry.rt;
    assign op_a    = rs_data;
    assign op_b    = alu_pkg::op_uses_imm(sel_entry.opcode) ? sel_entry.imm : rt_data;
    assign shamt   = op_b[4:0];

    always_comb begin
        case (sel_entry.opcode)
            alu_pkg::OP_ADD,
            alu_pkg::OP_ADDI: result = op_a + op_b;
            alu_pkg::OP_SUB:  result = op_a - op_b;
            alu_pkg::OP_AND,
            alu_pkg::OP_ANDI: result = op_a & op_b;
            alu_pkg::OP_OR,
            alu_pkg::OP_ORI:  result = op_a | op_b;
            alu_pkg::OP_XOR:  result = op_a ^ op_b;
            alu_pkg::OP_SLT:  result = (op_a < op_b) ? '1 : '0;   // all ones when less
            alu_pkg::OP_SLL:  result = op_a << shamt;
            alu_pkg::OP_SRL:  result = op_a >> shamt;
            alu_pkg::OP_SRA:  result = alu_pkg::word_t'($signed(op_a) >>> shamt);
            default:          result = '0;
        endcase
    end

    // park the result, tag comes back from the buffer
    assign res_wr_en = sel_found;
    assign res_data  = result;

    always_comb begin
        exec_pick       = '0;
        exec_pick.valid = sel_found;
        exec_pick.slot  = sel_idx;
        exec_pick.stamp = sel_entry.stamp;
        exec_pick.tag   = alloc_tag;      // where this result is stored
    end

endmodule

`default_nettype wire

//--- design/alu_pkg.sv
`default_nettype none

package alu_pkg;

    parameter int DEF_NUM_SLOTS    = 8;    // instruction window size
    parameter int DEF_RESULT_DEPTH = 32;   // parked results
    parameter int TAG_W            = 5;    // matches default depth

    typedef logic [31:0]      word_t;
    typedef logic [4:0]       reg_addr_t;
    typedef logic [5:0]       opcode_t;
    typedef logic [2:0]       status_t;
    typedef logic [2:0]       slot_idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    // register forms
    localparam opcode_t OP_ADD  = 6'b000000;
    localparam opcode_t OP_SUB  = 6'b000001;
    localparam opcode_t OP_AND  = 6'b000010;
    localparam opcode_t OP_OR   = 6'b000011;
    localparam opcode_t OP_XOR  = 6'b000100;
    localparam opcode_t OP_SLT  = 6'b000101;   // unsigned compare
    // immediate forms
    localparam opcode_t OP_ADDI = 6'b000110;
    localparam opcode_t OP_ANDI = 6'b000111;
    localparam opcode_t OP_ORI  = 6'b001000;
    // shifts, amount from low five bits of operand b
    localparam opcode_t OP_SLL  = 6'b010110;
    localparam opcode_t OP_SRL  = 6'b010111;
    localparam opcode_t OP_SRA  = 6'b011000;

    localparam status_t ST_EXEC_READY = 3'b100;   // issued, not executed
    localparam status_t ST_WB_READY   = 3'b001;

    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        word_t     imm;
        tag_t      tag;      // result location once executed
        status_t   stamp;
    } slot_entry_t;

    typedef struct packed {
        logic    stamp_en;
        status_t stamp;
        logic    take_en;
        tag_t    take;
    } slot_update_t;

    typedef struct packed {
        logic      valid;
        slot_idx_t slot;
        status_t   stamp;    // entry stamp of the picked slot
        tag_t      tag;
    } pick_t;

    // opcodes this unit executes, anything else is left for other units
    function automatic logic op_supported(opcode_t op);
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
            OP_ADDI, OP_ANDI, OP_ORI,
            OP_SLL, OP_SRL, OP_SRA: op_supported = 1'b1;
            default:                op_supported = 1'b0;
        endcase
    endfunction

    function automatic logic op_uses_imm(opcode_t op);
        op_uses_imm = (op == OP_ADDI) || (op == OP_ANDI) || (op == OP_ORI);
    endfunction

endpackage

`default_nettype wire

//--- design/alu_result_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module alu_result_buffer #(
    parameter int RESULT_DEPTH = 32
) (
    input  wire            clk,
    input  wire            arst_n,
    input  wire            wr_en,
    input  alu_pkg::word_t wr_data,
    output alu_pkg::tag_t  alloc_tag,
    input  alu_pkg::tag_t  rd_tag,
    output alu_pkg::word_t rd_data
);

    alu_pkg::word_t mem [RESULT_DEPTH];
    alu_pkg::tag_t  alloc_ptr;             // next free location
    alu_pkg::tag_t  alloc_ptr_nxt;

    // wraps at the depth, the oldest result gets overwritten
    always_comb begin
        if (alloc_ptr == alu_pkg::tag_t'(RESULT_DEPTH - 1)) begin
            alloc_ptr_nxt = '0;
        end else begin
            alloc_ptr_nxt = alloc_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alloc_ptr <= '0;
            for (int i = 0; i < RESULT_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[alloc_ptr] <= wr_data;     // lands at current tag
            alloc_ptr      <= alloc_ptr_nxt;
        end
    end

    assign alloc_tag = alloc_ptr;
    assign rd_data   = mem[rd_tag];        // combinational read for writeback

endmodule

`default_nettype wire

//--- design/alu_status_merge.sv
`timescale 1ns/10ps
`default_nettype none

module alu_status_merge #(
    parameter int NUM_SLOTS = 8
) (
    input  alu_pkg::pick_t                        exec_pick,
    input  alu_pkg::pick_t                        wb_pick,
    output alu_pkg::slot_update_t [NUM_SLOTS-1:0] slot_update
);

    alu_pkg::status_t exec_stamp;
    alu_pkg::status_t wb_stamp;

    // executed sets bit 2, written back sets bit 0, other bits kept
    assign exec_stamp = {1'b1, exec_pick.stamp[1:0]};
    assign wb_stamp   = {wb_pick.stamp[2:1], 1'b1};

    // both picks never address the same slot, a slot has one status
    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            slot_update[s] = '0;                  // untouched slots see no strobe
            if (exec_pick.valid && exec_pick.slot == alu_pkg::slot_idx_t'(s)) begin
                slot_update[s].stamp_en = 1'b1;
                slot_update[s].stamp    = exec_stamp;
                slot_update[s].take_en  = 1'b1;
                slot_update[s].take     = exec_pick.tag;
            end
            if (wb_pick.valid && wb_pick.slot == alu_pkg::slot_idx_t'(s)) begin
                slot_update[s].stamp_en = 1'b1;
                slot_update[s].stamp    = wb_stamp;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/alu_unit.sv
`timescale 1ns/10ps
`default_nettype none

module alu_unit #(
    parameter int NUM_SLOTS    = alu_pkg::DEF_NUM_SLOTS,
    parameter int RESULT_DEPTH = alu_pkg::DEF_RESULT_DEPTH
) (
    input  wire                                   clk,
    input  wire                                   arst_n,
    input  alu_pkg::status_t      [NUM_SLOTS-1:0] slot_status,
    input  alu_pkg::slot_entry_t  [NUM_SLOTS-1:0] slot_entry,
    output alu_pkg::slot_update_t [NUM_SLOTS-1:0] slot_update,
    output alu_pkg::reg_addr_t                    rs_addr,
    input  alu_pkg::word_t                        rs_data,
    output alu_pkg::reg_addr_t                    rt_addr,
    input  alu_pkg::word_t                        rt_data,
    output logic                                  rd_wr_en,
    output alu_pkg::reg_addr_t                    rd_addr,
    output alu_pkg::word_t                        rd_data
);

    logic           res_wr_en;
    alu_pkg::word_t res_data;
    alu_pkg::tag_t  alloc_tag;
    alu_pkg::tag_t  buf_rd_tag;
    alu_pkg::word_t buf_rd_data;
    alu_pkg::pick_t exec_pick;
    alu_pkg::pick_t wb_pick;

    alu_execute #(.NUM_SLOTS(NUM_SLOTS)) u_execute (
        .slot_status (slot_status),
        .slot_entry  (slot_entry),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .alloc_tag   (alloc_tag),
        .res_wr_en   (res_wr_en),
        .res_data    (res_data),
        .exec_pick   (exec_pick)
    );

    alu_result_buffer #(.RESULT_DEPTH(RESULT_DEPTH)) u_result_buffer (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_en     (res_wr_en),
        .wr_data   (res_data),
        .alloc_tag (alloc_tag),
        .rd_tag    (buf_rd_tag),
        .rd_data   (buf_rd_data)
    );

    alu_writeback #(.NUM_SLOTS(NUM_SLOTS)) u_writeback (
        .slot_status (slot_status),
        .slot_entry  (slot_entry),
        .rd_tag      (buf_rd_tag),
        .rd_data_buf (buf_rd_data),
        .rd_wr_en    (rd_wr_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .wb_pick     (wb_pick)
    );

    alu_status_merge #(.NUM_SLOTS(NUM_SLOTS)) u_status_merge (
        .exec_pick   (exec_pick),
        .wb_pick     (wb_pick),
        .slot_update (slot_update)
    );

endmodule

`default_nettype wire

//--- design/alu_writeback.sv
`timescale 1ns/10ps
`default_nettype none

module alu_writeback #(
    parameter int NUM_SLOTS = 8
) (
    input  alu_pkg::status_t     [NUM_SLOTS-1:0] slot_status,
    input  alu_pkg::slot_entry_t [NUM_SLOTS-1:0] slot_entry,
    output alu_pkg::tag_t                        rd_tag,
    input  alu_pkg::word_t                       rd_data_buf,
    output logic                                 rd_wr_en,
    output alu_pkg::reg_addr_t                   rd_addr,
    output alu_pkg::word_t                       rd_data,
    output alu_pkg::pick_t                       wb_pick
);

    logic                 sel_found;
    alu_pkg::slot_idx_t   sel_idx;
    alu_pkg::slot_entry_t sel_entry;

    // oldest writeback-ready slot
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (!sel_found && slot_status[i] == alu_pkg::ST_WB_READY &&
                alu_pkg::op_supported(slot_entry[i].opcode)) begin
                sel_found = 1'b1;
                sel_idx   = alu_pkg::slot_idx_t'(i);
            end
        end
    end

    assign sel_entry = slot_entry[sel_idx];

    // buffer read by tag, straight into the rd write port
    assign rd_tag   = sel_entry.tag;
    assign rd_wr_en = sel_found;
    assign rd_addr  = sel_entry.rd;
    assign rd_data  = rd_data_buf;

    always_comb begin
        wb_pick       = '0;
        wb_pick.valid = sel_found;
        wb_pick.slot  = sel_idx;
        wb_pick.stamp = sel_entry.stamp;
        wb_pick.tag   = sel_entry.tag;
    end

endmodule

`default_nettype wire

//--- filelist.f
design/alu_pkg.sv
design/alu_result_buffer.sv
design/alu_execute.sv
design/alu_writeback.sv
design/alu_status_merge.sv
design/alu_unit.sv
tests/alu_unit_properties.sv
tests/alu_unit_tb.sv

//--- tests/alu_unit_properties.sv
`timescale 1ns/10ps
`default_nettype none

module alu_unit_properties #(
    parameter int NUM_SLOTS = 8
) (
    input wire                                   clk,
    input wire                                   arst_n,
    input alu_pkg::status_t      [NUM_SLOTS-1:0] slot_status,
    input alu_pkg::slot_update_t [NUM_SLOTS-1:0] slot_update,
    input wire                                   rd_wr_en
);

    logic [NUM_SLOTS-1:0] take_vec;
    logic [NUM_SLOTS-1:0] exec_vec;       // executed stamp on an exec-ready slot
    logic [NUM_SLOTS-1:0] strobe_vec;
    logic [NUM_SLOTS-1:0] wb_ready_vec;

    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            take_vec[s]     = slot_update[s].take_en;
            exec_vec[s]     = slot_update[s].stamp_en && slot_update[s].stamp[2] &&
                              (slot_status[s] == alu_pkg::ST_EXEC_READY);
            strobe_vec[s]   = slot_update[s].stamp_en || slot_update[s].take_en;
            wb_ready_vec[s] = (slot_status[s] == alu_pkg::ST_WB_READY);
        end
    end

    one_take: assert property (@(posedge clk) disable iff (!arst_n) $countones(take_vec) <= 1)
        else $error("more than one take_en in one cycle");

    one_exec: assert property (@(posedge clk) disable iff (!arst_n) $countones(exec_vec) <= 1)
        else $error("more than one executed stamp in one cycle");

    quiet_in_reset: assert property (@(posedge clk) !arst_n |-> (strobe_vec == '0 && !rd_wr_en))
        else $error("strobe asserted while reset is active");

    wb_needs_ready: assert property (@(posedge clk) disable iff (!arst_n)
                                     rd_wr_en |-> (wb_ready_vec != '0))
        else $error("register write with no slot ready for writeback");

endmodule

bind alu_unit alu_unit_properties #(.NUM_SLOTS(NUM_SLOTS)) u_properties (
    .clk         (clk),
    .arst_n      (arst_n),
    .slot_status (slot_status),
    .slot_update (slot_update),
    .rd_wr_en    (rd_wr_en)
);

`default_nettype wire

//--- tests/alu_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module alu_unit_tb;

    localparam int NUM_SLOTS    = alu_pkg::DEF_NUM_SLOTS;
    localparam int RESULT_DEPTH = alu_pkg::DEF_RESULT_DEPTH;
    localparam int MAX_CYCLES   = 2000;                // well above the length of all tests
    localparam alu_pkg::status_t ST_IDLE = 3'b000;     // nothing for this unit
    localparam alu_pkg::opcode_t OP_MULT = 6'b011110;  // belongs to another unit

    logic                                  clk;
    logic                                  arst_n;
    alu_pkg::status_t      [NUM_SLOTS-1:0] slot_status;
    alu_pkg::slot_entry_t  [NUM_SLOTS-1:0] slot_entry;
    alu_pkg::slot_update_t [NUM_SLOTS-1:0] slot_update;
    alu_pkg::reg_addr_t                    rs_addr;
    alu_pkg::reg_addr_t                    rt_addr;
    alu_pkg::reg_addr_t                    rd_addr;
    alu_pkg::word_t                        rs_data;
    alu_pkg::word_t                        rt_data;
    alu_pkg::word_t                        rd_data;
    logic                                  rd_wr_en;

    alu_pkg::word_t                        regs [32];   // register file model
    alu_pkg::tag_t                         exp_ptr;     // expected allocation pointer
    logic [31:0]                           lcg_state;
    int                                    cycle_cnt = 0;
    alu_pkg::slot_update_t [NUM_SLOTS-1:0] upd_q;       // sampled mid-cycle
    logic                                  wr_en_q;
    alu_pkg::reg_addr_t                    wr_addr_q;
    alu_pkg::word_t                        wr_data_q;

    alu_unit #(
        .NUM_SLOTS    (NUM_SLOTS),
        .RESULT_DEPTH (RESULT_DEPTH)
    ) UUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .slot_status (slot_status),
        .slot_entry  (slot_entry),
        .slot_update (slot_update),
        .rs_addr     (rs_addr),
        .rs_data     (rs_data),
        .rt_addr     (rt_addr),
        .rt_data     (rt_data),
        .rd_wr_en    (rd_wr_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    assign rs_data = regs[rs_addr];   // combinational read ports
    assign rt_data = regs[rt_addr];

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            fail_run($sformatf("timeout, run still going after %0d cycles", MAX_CYCLES));
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "%s", msg);
    endtask

    function automatic alu_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 13);   // fold high bits into the low ones
    endfunction

    function automatic alu_pkg::word_t expected_result(input alu_pkg::opcode_t op,
                                                       input alu_pkg::word_t a,
                                                       input alu_pkg::word_t b);
        int sh;
        sh = int'(b[4:0]);
        case (op)
            alu_pkg::OP_ADD, alu_pkg::OP_ADDI: return a + b;
            alu_pkg::OP_SUB:                   return a - b;
            alu_pkg::OP_AND, alu_pkg::OP_ANDI: return a & b;
            alu_pkg::OP_OR, alu_pkg::OP_ORI:   return a | b;
            alu_pkg::OP_XOR:                   return a ^ b;
            alu_pkg::OP_SLT:                   return (a < b) ? 32'hffff_ffff : 32'h0;
            alu_pkg::OP_SLL:                   return a << sh;
            alu_pkg::OP_SRL:                   return a >> sh;
            alu_pkg::OP_SRA:   // sign fills the vacated top bits
                return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            default:                           return 32'h0;
        endcase
    endfunction

    function automatic alu_pkg::slot_entry_t make_entry(input alu_pkg::opcode_t op,
            input alu_pkg::reg_addr_t rs, input alu_pkg::reg_addr_t rt,
            input alu_pkg::reg_addr_t rd, input alu_pkg::word_t imm);
        alu_pkg::slot_entry_t e;
        e        = '0;
        e.opcode = op;
        e.rs     = rs;
        e.rt     = rt;
        e.rd     = rd;
        e.imm    = imm;
        e.stamp  = alu_pkg::ST_EXEC_READY;
        return e;
    endfunction

    // sample mid-cycle, then the window and register file apply the strobes after the edge
    task automatic step();
        int s;
        @(negedge clk);
        upd_q     = slot_update;
        wr_en_q   = rd_wr_en;
        wr_addr_q = rd_addr;
        wr_data_q = rd_data;
        @(posedge clk);
        #1;
        for (s = 0; s < NUM_SLOTS; s++) begin
            if (upd_q[s].stamp_en) begin
                slot_entry[s].stamp = upd_q[s].stamp;
                slot_status[s]      = ST_IDLE;   // stamped slot leaves the ready state
            end
            if (upd_q[s].take_en) begin
                slot_entry[s].tag = upd_q[s].take;
            end
        end
        if (wr_en_q) begin
            regs[wr_addr_q] = wr_data_q;
        end
    endtask

    task automatic no_strobes();
        int s;
        for (s = 0; s < NUM_SLOTS; s++) begin
            assert (!upd_q[s].stamp_en && !upd_q[s].take_en)
            else fail_run($sformatf("Mismatch at time %0t: unexpected strobe on slot %0d",
                                    $time, s));
        end
        assert (!wr_en_q)
        else fail_run($sformatf("Mismatch at time %0t: unexpected register write", $time));
    endtask

    // expects one execution on slot with the next pointer value as tag
    task automatic exec_landed(input int slot, input alu_pkg::status_t entry_stamp);
        alu_pkg::status_t exp_stamp;
        int s;
        exp_stamp = {1'b1, entry_stamp[1:0]};
        for (s = 0; s < NUM_SLOTS; s++) begin
            if (s == slot) begin
                assert (upd_q[s].stamp_en && upd_q[s].stamp == exp_stamp &&
                        upd_q[s].take_en && upd_q[s].take == exp_ptr)
                else fail_run($sformatf(
                    "Mismatch at time %0t: slot %0d stamp %b/%b take %b/%0d, expected %b take %0d",
                    $time, s, upd_q[s].stamp_en, upd_q[s].stamp, upd_q[s].take_en,
                    upd_q[s].take, exp_stamp, exp_ptr));
            end else begin
                assert (!upd_q[s].take_en)
                else fail_run($sformatf("Mismatch at time %0t: slot %0d took a tag", $time, s));
            end
        end
        exp_ptr = alu_pkg::tag_t'((int'(exp_ptr) + 1) % RESULT_DEPTH);
    endtask

    task automatic writeback_landed(input int slot, input alu_pkg::status_t entry_stamp,
                                    input alu_pkg::reg_addr_t rd, input alu_pkg::word_t value);
        alu_pkg::status_t exp_stamp;
        exp_stamp = {entry_stamp[2:1], 1'b1};
        assert (upd_q[slot].stamp_en && upd_q[slot].stamp == exp_stamp && !upd_q[slot].take_en)
        else fail_run($sformatf("Mismatch at time %0t: slot %0d writeback stamp %b, expected %b",
                                $time, slot, upd_q[slot].stamp, exp_stamp));
        assert (wr_en_q && wr_addr_q == rd && wr_data_q == value)
        else fail_run($sformatf("Mismatch at time %0t: write %b r%0d=%h, expected r%0d=%h",
                                $time, wr_en_q, wr_addr_q, wr_data_q, rd, value));
    endtask

    // issue in slot 3, execute, one idle cycle, then write back to r10
    task automatic run_alu_op(input alu_pkg::opcode_t op, input bit imm_form);
        alu_pkg::word_t   a;
        alu_pkg::word_t   b;
        alu_pkg::word_t   imm;
        alu_pkg::word_t   exp_val;
        alu_pkg::status_t entry_stamp;
        a       = lcg_next();
        b       = lcg_next();
        imm     = lcg_next();
        if (op == alu_pkg::OP_SRA) begin
            a[31] = 1'b1;   // negative operand and nonzero shift so the sign fill shows
            b[2]  = 1'b1;
        end
        exp_val = expected_result(op, a, imm_form ? imm : b);
        regs[1] = a;
        regs[2] = b;
        slot_entry[3]  = make_entry(op, 5'd1, 5'd2, 5'd10, imm);
        slot_status[3] = alu_pkg::ST_EXEC_READY;
        step();
        exec_landed(3, alu_pkg::ST_EXEC_READY);
        step();
        no_strobes();
        entry_stamp    = slot_entry[3].stamp;
        slot_status[3] = alu_pkg::ST_WB_READY;
        regs[1]        = ~a;   // value has to come from the buffer
        step();
        writeback_landed(3, entry_stamp, 5'd10, exp_val);
    endtask

    task automatic idle_after_reset();
        repeat (4) begin
            step();
            no_strobes();
        end
    endtask

    task automatic register_forms();
        alu_pkg::opcode_t ops [9];
        int i;
        ops = '{alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_AND, alu_pkg::OP_OR,
                alu_pkg::OP_XOR, alu_pkg::OP_SLT, alu_pkg::OP_SLL, alu_pkg::OP_SRL,
                alu_pkg::OP_SRA};
        for (i = 0; i < 9; i++) begin
            run_alu_op(ops[i], 1'b0);
        end
    endtask

    task automatic immediate_forms();
        run_alu_op(alu_pkg::OP_ADDI, 1'b1);
        run_alu_op(alu_pkg::OP_ANDI, 1'b1);
        run_alu_op(alu_pkg::OP_ORI, 1'b1);
    endtask

    task automatic advance_pointer_to(input alu_pkg::tag_t target);
        while (exp_ptr != target) begin
            slot_entry[0]  = make_entry(alu_pkg::OP_ADD, 5'd1, 5'd2, 5'd11, '0);
            slot_status[0] = alu_pkg::ST_EXEC_READY;
            step();
            exec_landed(0, alu_pkg::ST_EXEC_READY);
        end
    endtask

    task automatic oldest_first();
        advance_pointer_to(5'd30);   // takes run 30, 31, 0
        slot_entry[2]  = make_entry(alu_pkg::OP_ADD, 5'd1, 5'd2, 5'd14, '0);
        slot_entry[5]  = make_entry(alu_pkg::OP_SUB, 5'd1, 5'd2, 5'd15, '0);
        slot_entry[7]  = make_entry(alu_pkg::OP_OR, 5'd1, 5'd2, 5'd16, '0);
        slot_status[2] = alu_pkg::ST_EXEC_READY;
        slot_status[5] = alu_pkg::ST_EXEC_READY;
        slot_status[7] = alu_pkg::ST_EXEC_READY;
        step();
        exec_landed(7, alu_pkg::ST_EXEC_READY);
        step();
        exec_landed(5, alu_pkg::ST_EXEC_READY);
        step();
        exec_landed(2, alu_pkg::ST_EXEC_READY);
        step();
        no_strobes();
    endtask

    task automatic unsupported_skipped();
        slot_entry[6]  = make_entry(OP_MULT, 5'd1, 5'd2, 5'd17, '0);
        slot_entry[1]  = make_entry(alu_pkg::OP_AND, 5'd1, 5'd2, 5'd18, '0);
        slot_status[6] = alu_pkg::ST_EXEC_READY;
        slot_status[1] = alu_pkg::ST_EXEC_READY;
        step();
        exec_landed(1, alu_pkg::ST_EXEC_READY);
        assert (!upd_q[6].stamp_en)
        else fail_run($sformatf("Mismatch at time %0t: MULT slot 6 was stamped", $time));
        repeat (3) begin
            step();
            no_strobes();   // slot 6 stays ready and untouched
        end
        slot_status[6] = ST_IDLE;
    endtask

    task automatic exec_and_wb_together();
        alu_pkg::word_t a;
        alu_pkg::word_t b;
        alu_pkg::word_t exp_val;
        a              = lcg_next();
        b              = lcg_next();
        regs[1]        = a;
        regs[2]        = b;
        exp_val        = expected_result(alu_pkg::OP_XOR, a, b);
        slot_entry[1]  = make_entry(alu_pkg::OP_XOR, 5'd1, 5'd2, 5'd12, '0);
        slot_status[1] = alu_pkg::ST_EXEC_READY;
        step();
        exec_landed(1, alu_pkg::ST_EXEC_READY);
        slot_entry[1].stamp = 3'b110;   // bit 1 kept by the written-back stamp
        slot_status[1]      = alu_pkg::ST_WB_READY;
        slot_entry[4]       = make_entry(alu_pkg::OP_SUB, 5'd1, 5'd2, 5'd13, '0);
        slot_entry[4].stamp = 3'b010;   // bit 1 kept by the executed stamp
        slot_status[4]      = alu_pkg::ST_EXEC_READY;
        step();
        exec_landed(4, 3'b010);
        writeback_landed(1, 3'b110, 5'd12, exp_val);
    endtask

    initial begin
        int r;
        clk         = 1'b0;
        arst_n      = 1'b0;
        slot_status = '0;
        slot_entry  = '0;
        lcg_state   = 32'hacba;
        exp_ptr     = '0;
        for (r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        idle_after_reset();
        register_forms();
        immediate_forms();
        oldest_first();
        unsupported_skipped();
        exec_and_wb_together();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
